// File: logic/ac97_pkg.sv
`default_nettype none

package ac97_pkg;

	// ############################################################
	// Widths and link framing.
	// ############################################################

	localparam int PCM_BITS    = 20;                     // One audio slot.
	localparam int PAD_BITS    = 4;                      // Trailing zeros of a frame.
	localparam int FRAME_BITS  = 48;                     // Sync, tag, two valids, two slots, pad.
	localparam int FRAME_CNT_W = $clog2(FRAME_BITS);

	typedef logic [29:0]            word_addr_t;         // Address in 32-bit words.
	typedef logic [31:0]            byte_addr_t;         // Address as seen on the bus.
	typedef logic [15:0]            dma_count_t;         // Words left to move.
	typedef logic [31:0]            bus_word_t;
	typedef logic [PCM_BITS-1:0]    pcm_t;
	typedef logic [2:0]             csr_addr_t;
	typedef logic [FRAME_CNT_W-1:0] bit_cnt_t;           // Position inside a frame.

	localparam bit_cnt_t LAST_BIT = bit_cnt_t'(FRAME_BITS - 1);

	// Register map. The write channel mirrors the read channel three slots up.
	localparam csr_addr_t REG_RD_EN    = 3'd0;
	localparam csr_addr_t REG_RD_ADDR  = 3'd1;
	localparam csr_addr_t REG_RD_COUNT = 3'd2;
	localparam csr_addr_t REG_WR_EN    = 3'd3;
	localparam csr_addr_t REG_WR_ADDR  = 3'd4;
	localparam csr_addr_t REG_WR_COUNT = 3'd5;

	// ############################################################
	// Structs and the DMA state machine.
	// ############################################################

	typedef struct packed {
		logic left_valid;
		pcm_t left;
		logic right_valid;
		pcm_t right;
	} stereo_t;

	// Master request half of a classic single cycle.
	typedef struct packed {
		byte_addr_t adr;
		logic       we;
		bus_word_t  dat;
		logic       cyc_stb;
	} wb_req_t;

	typedef struct packed {
		logic       en;
		word_addr_t addr;
		dma_count_t remaining;
	} dma_chan_t;

	// Frame on the wire, sent MSB first, so sync goes out first.
	typedef struct packed {
		logic                sync;
		logic                tag;
		logic                left_valid;
		logic                right_valid;
		pcm_t                left;
		pcm_t                right;
		logic [PAD_BITS-1:0] pad;
	} frame_t;

	typedef enum logic [2:0] {
		IDLE,
		READ,
		WRITE,
		DOWN_DONE,
		UP_DONE
	} dma_state_t;

endpackage

`default_nettype wire

// File: logic/ac97_regs.sv
`default_nettype none

module ac97_regs (
	input  wire                        sys_clk,
	input  wire                        sys_rst,
	input  wire                        csr_we_i,
	input  wire ac97_pkg::csr_addr_t   csr_addr_i,
	input  wire ac97_pkg::bus_word_t   csr_wdata_i,
	output ac97_pkg::bus_word_t        csr_rdata_o,
	input  wire                        rd_next_i,
	input  wire                        wr_next_i,
	output ac97_pkg::dma_chan_t        rd_chan_o,
	output ac97_pkg::dma_chan_t        wr_chan_o,
	output logic                       irq_rd_o,
	output logic                       irq_wr_o
);

	ac97_pkg::dma_chan_t rd_q;   // Playback channel state.
	ac97_pkg::dma_chan_t wr_q;   // Capture channel state.

	// One transferred word moves the address on and counts down.
	// The last word also drops the enable.
	function automatic ac97_pkg::dma_chan_t chan_step(
		input ac97_pkg::dma_chan_t c,
		input logic                next
	);
		ac97_pkg::dma_chan_t r;
		r = c;
		if (next) begin
			r.addr      = c.addr + 1'b1;
			r.remaining = c.remaining - 1'b1;
			if (c.remaining == 16'd1)
				r.en = 1'b0;           // Transfer complete.
		end
		return r;
	endfunction

	// Software writes land on top of the bookkeeping, so a write wins a tie.
	function automatic ac97_pkg::dma_chan_t chan_write(
		input ac97_pkg::dma_chan_t c,
		input ac97_pkg::csr_addr_t base
	);
		ac97_pkg::dma_chan_t r;
		r = c;
		if (csr_we_i) begin
			if (csr_addr_i == base)
				r.en = csr_wdata_i[0];
			if (csr_addr_i == base + 3'd1)
				r.addr = csr_wdata_i[29:0];      // Word address.
			if (csr_addr_i == base + 3'd2)
				r.remaining = csr_wdata_i[15:0];
		end
		return r;
	endfunction

	// ############################################################
	// Channel state and interrupts.
	// ############################################################

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			rd_q     <= '0;
			wr_q     <= '0;
			irq_rd_o <= 1'b0;
			irq_wr_o <= 1'b0;
		end else begin
			rd_q <= chan_write(chan_step(rd_q, rd_next_i), ac97_pkg::REG_RD_EN);
			wr_q <= chan_write(chan_step(wr_q, wr_next_i), ac97_pkg::REG_WR_EN);
			// Pulse one cycle after the final word went through.
			irq_rd_o <= rd_next_i && (rd_q.remaining == 16'd1);
			irq_wr_o <= wr_next_i && (wr_q.remaining == 16'd1);
		end
	end

	assign rd_chan_o = rd_q;
	assign wr_chan_o = wr_q;

	// Readback is combinational from the index.
	always_comb begin
		case (csr_addr_i)
			ac97_pkg::REG_RD_EN:    csr_rdata_o = {31'd0, rd_q.en};
			ac97_pkg::REG_RD_ADDR:  csr_rdata_o = {2'd0, rd_q.addr};
			ac97_pkg::REG_RD_COUNT: csr_rdata_o = {16'd0, rd_q.remaining};
			ac97_pkg::REG_WR_EN:    csr_rdata_o = {31'd0, wr_q.en};
			ac97_pkg::REG_WR_ADDR:  csr_rdata_o = {2'd0, wr_q.addr};
			ac97_pkg::REG_WR_COUNT: csr_rdata_o = {16'd0, wr_q.remaining};
			default:                csr_rdata_o = '0;      // Unused indices read zero.
		endcase
	end

	// The DMA only moves words for a channel that software left enabled.
	assert property (@(posedge sys_clk) disable iff (sys_rst) rd_next_i |-> rd_q.en)
		else $error("playback word moved on a disabled channel");
	assert property (@(posedge sys_clk) disable iff (sys_rst) wr_next_i |-> wr_q.en)
		else $error("capture word moved on a disabled channel");

endmodule

`default_nettype wire

// File: logic/ac97_dma.sv
`default_nettype none

module ac97_dma (
	input  wire                        sys_clk,
	input  wire                        sys_rst,
	input  wire ac97_pkg::dma_chan_t   rd_chan_i,
	input  wire ac97_pkg::dma_chan_t   wr_chan_i,
	output logic                       rd_next_o,
	output logic                       wr_next_o,
	output ac97_pkg::wb_req_t          wb_o,
	input  wire                        wb_ack_i,
	input  wire ac97_pkg::bus_word_t   wb_dat_i,
	input  wire                        down_next_frame_i,
	output logic                       down_en_o,
	output ac97_pkg::stereo_t          down_sample_o,
	input  wire                        up_next_frame_i,
	output logic                       up_en_o,
	input  wire ac97_pkg::stereo_t     up_sample_i
);

	ac97_pkg::dma_state_t state_q;
	ac97_pkg::dma_state_t state_d;
	ac97_pkg::byte_addr_t adr_q;       // Bus address of the cycle in flight.
	ac97_pkg::bus_word_t  dat_q;       // Capture word, frozen for the whole cycle.

	logic down_pend_q;                 // Frame request seen while busy.
	logic up_pend_q;
	logic down_req;
	logic up_req;
	logic rd_ready;                    // Channel enabled with words left.
	logic wr_ready;
	logic load_rd_addr;
	logic load_wr_addr;
	logic load_down;

	// A request that lands while the bus is busy is kept until IDLE sees it.
	assign down_req = down_next_frame_i | down_pend_q;
	assign up_req   = up_next_frame_i | up_pend_q;
	assign rd_ready = rd_chan_i.en && (rd_chan_i.remaining != '0);
	assign wr_ready = wr_chan_i.en && (wr_chan_i.remaining != '0);

	// ############################################################
	// State machine.
	// ############################################################

	always_comb begin
		state_d      = state_q;
		down_en_o    = 1'b0;
		up_en_o      = 1'b0;
		rd_next_o    = 1'b0;
		wr_next_o    = 1'b0;
		load_rd_addr = 1'b0;
		load_wr_addr = 1'b0;
		load_down    = 1'b0;
		case (state_q)
			ac97_pkg::IDLE: begin
				// The link waits in any cycle where a request is being taken.
				down_en_o = !down_req;
				up_en_o   = !up_req;
				if (down_req && !rd_chan_i.en)
					load_down = 1'b1;          // Disabled playback sends silence.
				if (down_req && rd_ready) begin
					load_rd_addr = 1'b1;       // Playback has priority.
					state_d      = ac97_pkg::READ;
				end else if (up_req && wr_ready) begin
					load_wr_addr = 1'b1;
					state_d      = ac97_pkg::WRITE;
				end
			end
			ac97_pkg::READ: begin
				if (wb_ack_i) begin
					rd_next_o = 1'b1;
					load_down = 1'b1;          // Sample taken straight off the bus.
					state_d   = ac97_pkg::DOWN_DONE;
				end
			end
			ac97_pkg::WRITE: begin
				if (wb_ack_i) begin
					wr_next_o = 1'b1;
					state_d   = ac97_pkg::UP_DONE;
				end
			end
			ac97_pkg::DOWN_DONE: begin
				down_en_o = 1'b1;              // New sample is ready for the framer.
				state_d   = ac97_pkg::IDLE;
			end
			ac97_pkg::UP_DONE: begin
				up_en_o = 1'b1;
				state_d = ac97_pkg::IDLE;
			end
			default: state_d = ac97_pkg::IDLE;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state_q     <= ac97_pkg::IDLE;
			down_pend_q <= 1'b0;
			up_pend_q   <= 1'b0;
		end else begin
			state_q <= state_d;
			// IDLE always consumes a playback request.
			down_pend_q <= (state_q != ac97_pkg::IDLE) && down_req;
			// A capture request survives an IDLE cycle lost to playback.
			up_pend_q <= up_req && ((state_q != ac97_pkg::IDLE) || (down_req && rd_ready));
		end
	end

	// ############################################################
	// Bus request and sample registers.
	// ############################################################

	always_ff @(posedge sys_clk) begin
		if (load_rd_addr) begin
			adr_q <= {rd_chan_i.addr, 2'b00};
		end else if (load_wr_addr) begin
			adr_q <= {wr_chan_i.addr, 2'b00};
			dat_q <= {up_sample_i.left[19:4], up_sample_i.right[19:4]};   // 16 MSBs of each.
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			down_sample_o <= '0;
		end else if (load_down) begin
			down_sample_o.left_valid  <= rd_chan_i.en;
			down_sample_o.right_valid <= rd_chan_i.en;
			down_sample_o.left        <= {wb_dat_i[31:16], wb_dat_i[30:27]};
			down_sample_o.right       <= {wb_dat_i[15:0], wb_dat_i[14:11]};
		end
	end

	always_comb begin
		wb_o.adr     = adr_q;
		wb_o.we      = (state_q == ac97_pkg::WRITE);
		wb_o.dat     = dat_q;
		wb_o.cyc_stb = (state_q == ac97_pkg::READ) || (state_q == ac97_pkg::WRITE);
	end

	// A bus cycle belongs to an enabled channel in the matching direction.
	assert property (@(posedge sys_clk) disable iff (sys_rst)
		wb_o.cyc_stb |-> (state_q == ac97_pkg::READ && rd_chan_i.en) ||
			(state_q == ac97_pkg::WRITE && wr_chan_i.en))
		else $error("bus cycle outside an enabled transfer");
	// The request holds until the slave acks.
	assert property (@(posedge sys_clk) disable iff (sys_rst)
		wb_o.cyc_stb && !wb_ack_i |=> wb_o.cyc_stb && $stable(wb_o.adr) &&
			$stable(wb_o.we) && (!wb_o.we || $stable(wb_o.dat)))
		else $error("bus request changed before ack");

endmodule

`default_nettype wire

// File: logic/ac97_framer.sv
`default_nettype none

module ac97_framer (
	input  wire                        sys_clk,
	input  wire                        sys_rst,
	input  wire                        down_en_i,
	input  wire ac97_pkg::stereo_t     down_sample_i,
	output logic                       down_next_frame_o,
	output logic                       sdata_o
);

	ac97_pkg::frame_t                  frame_d;     // Frame built from the DMA sample.
	logic [ac97_pkg::FRAME_BITS-1:0]   shift_q;
	ac97_pkg::bit_cnt_t                bit_cnt_q;
	logic                              sending_q;   // A frame is on the wire.
	logic                              waiting_q;   // Request issued, sample not yet taken.

	// A sample without any valid slot goes out as an empty frame.
	// The line then stays low for the whole frame and carries no sync.
	always_comb begin
		frame_d = '0;
		if (down_sample_i.left_valid || down_sample_i.right_valid) begin
			frame_d.sync        = 1'b1;
			frame_d.tag         = 1'b1;
			frame_d.left_valid  = down_sample_i.left_valid;
			frame_d.right_valid = down_sample_i.right_valid;
			frame_d.left        = down_sample_i.left;
			frame_d.right       = down_sample_i.right;
		end
	end

	// ############################################################
	// Frame sequencing.
	// ############################################################

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			bit_cnt_q         <= '0;
			sending_q         <= 1'b0;
			waiting_q         <= 1'b0;
			down_next_frame_o <= 1'b0;
		end else begin
			down_next_frame_o <= 1'b0;
			if (sending_q) begin
				bit_cnt_q <= bit_cnt_q + 1'b1;
				if (bit_cnt_q == ac97_pkg::LAST_BIT) begin
					bit_cnt_q         <= '0;
					sending_q         <= 1'b0;
					down_next_frame_o <= 1'b1;   // Ask for the next sample.
				end
			end else if (waiting_q) begin
				// The link is idle low until the DMA says the sample is in place.
				if (down_en_i) begin
					sending_q <= 1'b1;
					waiting_q <= 1'b0;
				end
			end else if (down_next_frame_o) begin
				waiting_q <= 1'b1;               // Ignore down_en in the request cycle.
			end else begin
				down_next_frame_o <= 1'b1;       // First request after reset.
			end
		end
	end

	// Shift register. It loads on the cycle the sample is accepted.
	always_ff @(posedge sys_clk) begin
		if (waiting_q && down_en_i && !sending_q)
			shift_q <= frame_d;
		else if (sending_q)
			shift_q <= {shift_q[ac97_pkg::FRAME_BITS-2:0], 1'b0};
	end

	assign sdata_o = sending_q & shift_q[ac97_pkg::FRAME_BITS-1];   // MSB first.

endmodule

`default_nettype wire

// File: logic/ac97_deframer.sv
`default_nettype none

module ac97_deframer (
	input  wire                        sys_clk,
	input  wire                        sys_rst,
	input  wire                        sdata_i,
	input  wire                        up_en_i,
	output logic                       up_next_frame_o,
	output ac97_pkg::stereo_t          up_sample_o
);

	logic [ac97_pkg::FRAME_BITS-2:0]   shift_q;     // Every bit but the current one.
	ac97_pkg::bit_cnt_t                bit_cnt_q;
	logic                              in_frame_q;  // Sync found, frame being collected.
	logic                              pend_q;      // Tagged frame not yet handed over.
	ac97_pkg::frame_t                  rx_frame;
	logic                              frame_done;
	logic                              tagged_done;

	// The current input bit completes the frame on its last cycle.
	assign rx_frame    = {shift_q, sdata_i};
	assign frame_done  = in_frame_q && (bit_cnt_q == ac97_pkg::LAST_BIT);
	assign tagged_done = frame_done && rx_frame.tag;

	// ############################################################
	// Sync hunter and bit counter.
	// ############################################################

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			bit_cnt_q       <= '0;
			in_frame_q      <= 1'b0;
			pend_q          <= 1'b0;
			up_next_frame_o <= 1'b0;
		end else begin
			if (in_frame_q) begin
				bit_cnt_q <= bit_cnt_q + 1'b1;
				if (frame_done) begin
					bit_cnt_q  <= '0;
					in_frame_q <= 1'b0;      // Back to hunting.
				end
			end else if (sdata_i) begin
				// Between frames the line is low, so the first 1 is a sync bit.
				bit_cnt_q  <= ac97_pkg::bit_cnt_t'(1);
				in_frame_q <= 1'b1;
			end
			// Hold the announcement until the DMA can take it.
			up_next_frame_o <= 1'b0;
			if (tagged_done || pend_q) begin
				if (up_en_i) begin
					up_next_frame_o <= 1'b1;
					pend_q          <= 1'b0;
				end else begin
					pend_q <= 1'b1;
				end
			end
		end
	end

	// ############################################################
	// Shift register and slot unpacking.
	// ############################################################

	always_ff @(posedge sys_clk) begin
		shift_q <= {shift_q[ac97_pkg::FRAME_BITS-3:0], sdata_i};
	end

	// The sample stays put until the next tagged frame.
	always_ff @(posedge sys_clk) begin
		if (tagged_done) begin
			up_sample_o.left_valid  <= rx_frame.left_valid;
			up_sample_o.left        <= rx_frame.left;
			up_sample_o.right_valid <= rx_frame.right_valid;
			up_sample_o.right       <= rx_frame.right;
		end
	end

endmodule

`default_nettype wire

// File: logic/ac97_top.sv
`default_nettype none

module ac97_top (
	input  wire                        sys_clk,
	input  wire                        sys_rst,
	// Register bus.
	input  wire                        csr_we_i,
	input  wire ac97_pkg::csr_addr_t   csr_addr_i,
	input  wire ac97_pkg::bus_word_t   csr_wdata_i,
	output wire ac97_pkg::bus_word_t   csr_rdata_o,
	// Memory master port.
	output wire ac97_pkg::wb_req_t     wb_o,
	input  wire                        wb_ack_i,
	input  wire ac97_pkg::bus_word_t   wb_dat_i,
	// Serial link.
	output wire                        sdata_o,
	input  wire                        sdata_i,
	output wire                        irq_rd_o,
	output wire                        irq_wr_o
);

	wire ac97_pkg::dma_chan_t rd_chan;
	wire ac97_pkg::dma_chan_t wr_chan;
	wire                      rd_next;
	wire                      wr_next;
	wire                      down_next_frame;
	wire                      down_en;
	wire ac97_pkg::stereo_t   down_sample;    // DMA to framer.
	wire                      up_next_frame;
	wire                      up_en;
	wire ac97_pkg::stereo_t   up_sample;      // Deframer to DMA.

	ac97_regs regs_inst (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.csr_we_i(csr_we_i), .csr_addr_i(csr_addr_i),
		.csr_wdata_i(csr_wdata_i), .csr_rdata_o(csr_rdata_o),
		.rd_next_i(rd_next), .wr_next_i(wr_next),
		.rd_chan_o(rd_chan), .wr_chan_o(wr_chan),
		.irq_rd_o(irq_rd_o), .irq_wr_o(irq_wr_o)
	);

	ac97_dma dma_inst (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.rd_chan_i(rd_chan), .wr_chan_i(wr_chan),
		.rd_next_o(rd_next), .wr_next_o(wr_next),
		.wb_o(wb_o), .wb_ack_i(wb_ack_i), .wb_dat_i(wb_dat_i),
		.down_next_frame_i(down_next_frame), .down_en_o(down_en),
		.down_sample_o(down_sample),
		.up_next_frame_i(up_next_frame), .up_en_o(up_en),
		.up_sample_i(up_sample)
	);

	ac97_framer framer_inst (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.down_en_i(down_en), .down_sample_i(down_sample),
		.down_next_frame_o(down_next_frame), .sdata_o(sdata_o)
	);

	ac97_deframer deframer_inst (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.sdata_i(sdata_i), .up_en_i(up_en),
		.up_next_frame_o(up_next_frame), .up_sample_o(up_sample)
	);

endmodule

`default_nettype wire

// File: test/ac97_clkgen.sv
`default_nettype none

module ac97_clkgen (
	output logic sys_clk_o,
	output logic sys_rst_o
);

	localparam int HALF_PERIOD  = 4;   // Eight time units per cycle.
	localparam int RESET_CYCLES = 5;

	initial begin
		sys_clk_o = 1'b0;
		forever #HALF_PERIOD sys_clk_o = ~sys_clk_o;
	end

	// Reset drops a little after an edge, in step with the other inputs.
	initial begin
		sys_rst_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge sys_clk_o);
		#1;
		sys_rst_o = 1'b0;
	end

endmodule

`default_nettype wire

// File: test/ac97_tb.sv
`default_nettype none

module ac97_tb;

	localparam int MEM_WORDS = 512;   // Word-addressed memory behind the master port.
	localparam int NUM_ROWS  = 4;

	// One transfer per row. The end addresses are base plus count.
	typedef struct packed {
		ac97_pkg::word_addr_t src;
		ac97_pkg::word_addr_t dst;
		ac97_pkg::dma_count_t count;
		logic                 capture;    // Capture channel enabled.
		ac97_pkg::word_addr_t rd_end;     // Expected playback address afterwards.
		ac97_pkg::word_addr_t wr_end;     // Expected capture address afterwards.
	} row_t;

	localparam row_t ROWS [NUM_ROWS] = '{
		'{src: 30'd16,  dst: 30'd256, count: 16'd8,  capture: 1'b1, rd_end: 30'd24,  wr_end: 30'd264},
		'{src: 30'd40,  dst: 30'd320, count: 16'd1,  capture: 1'b1, rd_end: 30'd41,  wr_end: 30'd321},
		'{src: 30'd64,  dst: 30'd400, count: 16'd6,  capture: 1'b0, rd_end: 30'd70,  wr_end: 30'd400},
		'{src: 30'd100, dst: 30'd448, count: 16'd12, capture: 1'b1, rd_end: 30'd112, wr_end: 30'd460}
	};

	wire                        sys_clk;
	wire                        sys_rst;
	logic                       csr_we;
	ac97_pkg::csr_addr_t        csr_addr;
	ac97_pkg::bus_word_t        csr_wdata;
	wire ac97_pkg::bus_word_t   csr_rdata;
	wire ac97_pkg::wb_req_t     wb;
	logic                       wb_ack;
	ac97_pkg::bus_word_t        wb_rdata;
	wire                        sdata_loop;    // Serial output fed straight back in.
	wire                        irq_rd;
	wire                        irq_wr;

	ac97_pkg::bus_word_t mem [MEM_WORDS];      // Memory seen by the DUT.
	ac97_pkg::bus_word_t ref_mem [MEM_WORDS];  // What the memory should hold.
	ac97_pkg::dma_count_t rd_irqs;             // Pulses seen in the current row.
	ac97_pkg::dma_count_t wr_irqs;
	logic win_open;                            // Bus writes allowed at all.
	int   win_lo;                              // Writable word range, upper bound excluded.
	int   win_hi;

	ac97_clkgen clkgen_inst (
		.sys_clk_o(sys_clk),
		.sys_rst_o(sys_rst)
	);

	ac97_top ac97_top_inst (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.csr_we_i(csr_we), .csr_addr_i(csr_addr),
		.csr_wdata_i(csr_wdata), .csr_rdata_o(csr_rdata),
		.wb_o(wb), .wb_ack_i(wb_ack), .wb_dat_i(wb_rdata),
		.sdata_o(sdata_loop), .sdata_i(sdata_loop),
		.irq_rd_o(irq_rd), .irq_wr_o(irq_wr)
	);

	// ############################################################
	// Helpers.
	// ############################################################

	// Every word differs, and each one depends on all address bits.
	function automatic ac97_pkg::bus_word_t fill_word(input int idx);
		return (32'(idx) * 32'h9E37_79B9) ^ 32'h5A5A_0F0F;
	endfunction

	// A word costs about one frame plus the fetch, and each row gets two spare frames.
	function automatic int watchdog_cycles();
		int total;
		int r;
		total = 1000;                          // Reset checks and slack.
		for (r = 0; r < NUM_ROWS; r++) begin
			total += (int'(ROWS[r].count) + 2) * (ac97_pkg::FRAME_BITS + 8);
			total += 4 * ac97_pkg::FRAME_BITS; // Register access and link drain.
		end
		return total;
	endfunction

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_word(input ac97_pkg::bus_word_t got, input ac97_pkg::bus_word_t exp,
		input string what);
		if (got !== exp)
			abort_run($sformatf("Mismatch at time %0t: %s, got 0x%08h, expected 0x%08h",
				$time, what, got, exp));
	endtask

	task automatic check_count(input ac97_pkg::dma_count_t got, input ac97_pkg::dma_count_t exp,
		input string what);
		if (got !== exp)
			abort_run($sformatf("Mismatch at time %0t: %s, got %0d, expected %0d",
				$time, what, got, exp));
	endtask

	// A write is held for one cycle and lands on the following edge.
	task automatic csr_write(input ac97_pkg::csr_addr_t addr, input ac97_pkg::bus_word_t data);
		@(posedge sys_clk);
		#1;
		csr_we    = 1'b1;
		csr_addr  = addr;
		csr_wdata = data;
		@(posedge sys_clk);
		#1;
		csr_we = 1'b0;
	endtask

	// Read data is combinational, so it is taken in the middle of the cycle.
	task automatic csr_read(input ac97_pkg::csr_addr_t addr, output ac97_pkg::bus_word_t data);
		@(posedge sys_clk);
		#1;
		csr_addr = addr;
		#2;
		data = csr_rdata;
	endtask

	// ############################################################
	// Memory slave with random wait states.
	// ############################################################

	initial begin : bus_model
		int unsigned wait_left;
		logic        busy;
		int          idx;
		void'($urandom(52));                 // Same wait-state sequence on every run.
		wb_ack    = 1'b0;
		wb_rdata  = '0;
		busy      = 1'b0;
		wait_left = 0;
		forever begin
			@(posedge sys_clk);
			#1;
			wb_ack   = 1'b0;
			wb_rdata = '0;
			if (!sys_rst && wb.cyc_stb) begin
				if (!busy) begin
					busy      = 1'b1;
					wait_left = $urandom % 4;        // Zero to three wait states.
				end
				if (wait_left == 0) begin
					busy = 1'b0;
					idx  = int'(wb.adr[31:2]);
					if (wb.adr[1:0] != 2'b00 || idx >= MEM_WORDS)
						abort_run($sformatf("bus access to byte address 0x%08h outside the memory",
							wb.adr));
					if (wb.we) begin
						// Writes may only hit the capture buffer of the running row.
						if (!win_open || idx < win_lo || idx >= win_hi)
							abort_run($sformatf("unexpected bus write to word address %0d", idx));
						mem[idx] = wb.dat;
					end else begin
						wb_rdata = mem[idx];
					end
					wb_ack = 1'b1;                  // Ends the cycle at the next edge.
				end else begin
					wait_left = wait_left - 1;
				end
			end
		end
	end

	// Counts cycles with an interrupt high, so a long pulse shows up as extra.
	initial begin : irq_monitor
		forever begin
			@(posedge sys_clk);
			#2;
			if (irq_rd === 1'b1)
				rd_irqs = rd_irqs + 16'd1;
			if (irq_wr === 1'b1)
				wr_irqs = wr_irqs + 16'd1;
		end
	end

	initial begin : watchdog
		int limit;
		limit = watchdog_cycles();
		repeat (limit) @(posedge sys_clk);
		abort_run($sformatf("Timeout: transfers did not finish within %0d clock cycles", limit));
	end

	// ############################################################
	// Test sequence.
	// ############################################################

	task automatic check_reset_state();
		ac97_pkg::bus_word_t rdata;
		int                  n;
		csr_read(ac97_pkg::REG_RD_COUNT, rdata);
		check_count(rdata[15:0], 16'd0, "playback count after reset");
		csr_read(ac97_pkg::REG_WR_COUNT, rdata);
		check_count(rdata[15:0], 16'd0, "capture count after reset");
		// With playback off the framer sends empty frames, so the line stays low.
		for (n = 0; n < 2 * ac97_pkg::FRAME_BITS; n++) begin
			@(posedge sys_clk);
			#2;
			if (sdata_loop !== 1'b0)
				abort_run("serial output went high after reset with playback disabled");
			if (irq_rd !== 1'b0 || irq_wr !== 1'b0)
				abort_run("an interrupt was raised after reset with both channels idle");
			if (wb.cyc_stb !== 1'b0)
				abort_run("a bus cycle started after reset with both channels idle");
		end
	endtask

	task automatic run_row(input int r);
		row_t                row;
		ac97_pkg::bus_word_t rdata;
		int                  i;
		row     = ROWS[r];
		rd_irqs = '0;
		wr_irqs = '0;
		win_open = row.capture;
		win_lo   = int'(row.dst);
		win_hi   = int'(row.dst) + int'(row.count);
		// Capture is armed first so that the first looped-back frame finds it ready.
		csr_write(ac97_pkg::REG_WR_ADDR, {2'b00, row.dst});
		csr_write(ac97_pkg::REG_WR_COUNT, row.capture ? {16'd0, row.count} : 32'd0);
		csr_write(ac97_pkg::REG_WR_EN, {31'd0, row.capture});
		csr_write(ac97_pkg::REG_RD_ADDR, {2'b00, row.src});
		csr_write(ac97_pkg::REG_RD_COUNT, {16'd0, row.count});
		csr_write(ac97_pkg::REG_RD_EN, 32'd1);
		wait (rd_irqs != 16'd0);
		if (row.capture)
			wait (wr_irqs != 16'd0);
		// The last frame may still be on the wire. Let it pass before the next row.
		repeat (2 * ac97_pkg::FRAME_BITS) @(posedge sys_clk);
		win_open = 1'b0;
		csr_read(ac97_pkg::REG_RD_ADDR, rdata);
		check_word(rdata, {2'b00, row.rd_end}, $sformatf("playback address after row %0d", r));
		csr_read(ac97_pkg::REG_RD_COUNT, rdata);
		check_count(rdata[15:0], 16'd0, $sformatf("playback count after row %0d", r));
		csr_read(ac97_pkg::REG_RD_EN, rdata);
		check_word(rdata, 32'd0, $sformatf("playback enable after row %0d", r));
		csr_read(ac97_pkg::REG_WR_ADDR, rdata);
		check_word(rdata, {2'b00, row.wr_end}, $sformatf("capture address after row %0d", r));
		csr_read(ac97_pkg::REG_WR_COUNT, rdata);
		check_count(rdata[15:0], 16'd0, $sformatf("capture count after row %0d", r));
		csr_read(ac97_pkg::REG_WR_EN, rdata);
		check_word(rdata, 32'd0, $sformatf("capture enable after row %0d", r));
		check_count(rd_irqs, 16'd1, $sformatf("playback interrupts in row %0d", r));
		check_count(wr_irqs, row.capture ? 16'd1 : 16'd0,
			$sformatf("capture interrupts in row %0d", r));
		// Loopback copies the source buffer. Every other word keeps its old value.
		if (row.capture) begin
			for (i = 0; i < int'(row.count); i++)
				ref_mem[int'(row.dst) + i] = ref_mem[int'(row.src) + i];
		end
		for (i = 0; i < MEM_WORDS; i++)
			check_word(mem[i], ref_mem[i], $sformatf("memory word %0d after row %0d", i, r));
	endtask

	initial begin : main_test
		int r;
		int i;
		csr_we    = 1'b0;
		csr_addr  = '0;
		csr_wdata = '0;
		rd_irqs   = '0;
		wr_irqs   = '0;
		win_open  = 1'b0;
		win_lo    = 0;
		win_hi    = 0;
		for (i = 0; i < MEM_WORDS; i++) begin
			mem[i]     = fill_word(i);
			ref_mem[i] = fill_word(i);
		end
		do
			@(posedge sys_clk);
		while (sys_rst !== 1'b0);
		check_reset_state();
		for (r = 0; r < NUM_ROWS; r++)
			run_row(r);
		// Any failed check has already stopped the run.
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
logic/ac97_pkg.sv
logic/ac97_regs.sv
logic/ac97_dma.sv
logic/ac97_framer.sv
logic/ac97_deframer.sv
logic/ac97_top.sv
test/ac97_clkgen.sv
test/ac97_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := ac97_tb
FILELIST  := filelist.f
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP)
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := TESTBENCH PASSED
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes.
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
